// ==== capture_pkg.sv ====
package capture_pkg;

   // buffer geometry.
   localparam int DATA_W    = 32;
   localparam int ADDR_W    = 10;
   localparam int DEPTH     = 1 << ADDR_W;   // 1024 words per capture.
   localparam int BANK_W    = 2;
   localparam int NUM_BANKS = 1 << BANK_W;
   localparam int ROW_W     = ADDR_W - BANK_W;

   // word k sits in bank k mod NUM_BANKS at row k / NUM_BANKS, so the
   // low BANK_W address bits pick the bank and the rest form the row.

   // one write request to a bank, acted on at the next edge.
   typedef struct packed {
      logic              en;
      logic [ROW_W-1:0]  row;
      logic [DATA_W-1:0] data;
   } bank_wr_t;

   // one read request to a bank, acted on at the next edge.
   typedef struct packed {
      logic             en;
      logic [ROW_W-1:0] row;
   } bank_rd_t;

endpackage

// ==== capture_bank.sv ====
`timescale 1ns/100ps

module capture_bank (
   input  logic                           clk,
   input  logic                           rst,
   input  capture_pkg::bank_wr_t          wr_req,
   input  capture_pkg::bank_rd_t          rd_req,
   output logic [capture_pkg::DATA_W-1:0] rd_data
);

   import capture_pkg::*;

   localparam int ROWS = 1 << ROW_W;

   logic [DATA_W-1:0] mem [ROWS];   // contents undefined until written.

   // write port.
   always_ff @(posedge clk) begin
      if (wr_req.en) begin
         mem[wr_req.row] <= wr_req.data;
      end
   end

   // registered read port; the word comes back one edge after the request
   // and holds while no read is asked for.
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_data <= '0;
      end else if (rd_req.en) begin
         rd_data <= mem[rd_req.row];
      end
   end

endmodule

// ==== capture_writer.sv ====
`timescale 1ns/100ps

module capture_writer (
   input  logic                          clk,
   input  logic                          rst,
   input  logic [capture_pkg::DATA_W-1:0] data_in,
   output capture_pkg::bank_wr_t         wr_req [capture_pkg::NUM_BANKS],
   output logic                          fill_done
);

   import capture_pkg::*;

   logic [ADDR_W-1:0] wr_addr;     // address of the word sampled at this edge.
   logic              wr_valid;    // a request is pending for the banks.
   logic [BANK_W-1:0] wr_bank;
   logic [ROW_W-1:0]  wr_row;
   logic [DATA_W-1:0] wr_data;
   logic              last_addr;

   assign last_addr = (wr_addr == ADDR_W'(DEPTH - 1));

   // control path of the fill. it runs once after reset and then parks
   // with fill_done high until the next reset.
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_addr   <= '0;
         wr_valid  <= 1'b0;
         fill_done <= 1'b0;
      end else if (!fill_done) begin
         wr_valid <= 1'b1;
         wr_addr  <= wr_addr + 1'b1;
         if (last_addr) begin
            fill_done <= 1'b1;   // last word is in flight.
         end
      end else begin
         wr_valid <= 1'b0;       // writes stop once the fill is done.
      end
   end

   // payload of the request. it only matters while wr_valid is set.
   always_ff @(posedge clk) begin
      if (!fill_done) begin
         wr_bank <= wr_addr[BANK_W-1:0];
         wr_row  <= wr_addr[ADDR_W-1:BANK_W];
         wr_data <= data_in;
      end
   end

   // steer the single pending request to its bank; all other banks see
   // an idle request in the same cycle.
   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         wr_req[b].en   = wr_valid && (wr_bank == BANK_W'(b));
         wr_req[b].row  = wr_row;
         wr_req[b].data = wr_data;
      end
   end

endmodule

// ==== playback_reader.sv ====
`timescale 1ns/100ps

module playback_reader (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           fill_done,
   output capture_pkg::bank_rd_t          rd_req  [capture_pkg::NUM_BANKS],
   input  logic [capture_pkg::DATA_W-1:0] rd_data [capture_pkg::NUM_BANKS],
   output logic [capture_pkg::DATA_W-1:0] data_out,
   output logic                           playback_valid
);

   import capture_pkg::*;

   // read address, wraps from DEPTH-1 back to 0 on its own.
   logic [ADDR_W-1:0] rd_addr;

   // issue stage: the request seen by the banks.
   logic              iss_valid;
   logic [BANK_W-1:0] iss_bank;
   logic [ROW_W-1:0]  iss_row;

   // return stage: banks hold the word, this says which one to take.
   logic              ret_valid;
   logic [BANK_W-1:0] ret_bank;

   // address counter and issue stage.
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_addr   <= '0;
         iss_valid <= 1'b0;
      end else if (fill_done) begin
         rd_addr   <= rd_addr + 1'b1;   // one read per cycle, forever.
         iss_valid <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_done) begin
         iss_bank <= rd_addr[BANK_W-1:0];
         iss_row  <= rd_addr[ADDR_W-1:BANK_W];
      end
   end

   // only the addressed bank sees an enabled request.
   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         rd_req[b].en  = iss_valid && (iss_bank == BANK_W'(b));
         rd_req[b].row = iss_row;
      end
   end

   // bank select follows the request by one edge, in step with the
   // bank's registered read port.
   always_ff @(posedge clk) begin
      if (rst) begin
         ret_valid <= 1'b0;
      end else begin
         ret_valid <= iss_valid;
      end
   end

   always_ff @(posedge clk) begin
      ret_bank <= iss_bank;
   end

   // output stage.
   // the first word lands two edges after the first request, and from
   // then on the valid bit never drops until reset.
   always_ff @(posedge clk) begin
      if (rst) begin
         data_out       <= '0;
         playback_valid <= 1'b0;
      end else if (ret_valid) begin
         data_out       <= rd_data[ret_bank];
         playback_valid <= 1'b1;
      end
   end

endmodule

// ==== capture_playback_top.sv ====
`timescale 1ns/100ps

module capture_playback_top (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [capture_pkg::DATA_W-1:0] data_in,
   output logic [capture_pkg::DATA_W-1:0] data_out,
   output logic                           playback_valid
);

   import capture_pkg::*;

   bank_wr_t          wr_req  [NUM_BANKS];
   bank_rd_t          rd_req  [NUM_BANKS];
   logic [DATA_W-1:0] rd_data [NUM_BANKS];
   logic              fill_done;

   // fills the banks once after reset.
   capture_writer capture_writer_inst (
      .clk       (clk),
      .rst       (rst),
      .data_in   (data_in),
      .wr_req    (wr_req),
      .fill_done (fill_done)
   );

   // word-interleaved storage, one bank per low address value.
   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      capture_bank capture_bank_inst (
         .clk     (clk),
         .rst     (rst),
         .wr_req  (wr_req[b]),
         .rd_req  (rd_req[b]),
         .rd_data (rd_data[b])
      );
   end

   // loops over the stored words once the fill is done.
   playback_reader playback_reader_inst (
      .clk            (clk),
      .rst            (rst),
      .fill_done      (fill_done),
      .rd_req         (rd_req),
      .rd_data        (rd_data),
      .data_out       (data_out),
      .playback_valid (playback_valid)
   );

endmodule

// ==== capture_playback_sva.sv ====
`timescale 1ns/100ps

module capture_playback_sva (
   input logic                           clk,
   input logic                           rst,
   input logic [capture_pkg::DATA_W-1:0] data_out,
   input logic                           playback_valid
);

   import capture_pkg::*;

   int unsigned since_release;   // edges with rst low, saturating.

   always_ff @(posedge clk) begin
      if (rst) begin
         since_release <= 0;
      end else if (since_release < DEPTH + 8) begin
         since_release <= since_release + 1;
      end
   end

   // once playing, the valid level only drops on reset.
   valid_holds : assert property (@(posedge clk) $fell(playback_valid) |-> $past(rst))
      else $error("playback_valid fell without a reset");

   data_zero_in_reset : assert property (@(posedge clk) rst |=> (data_out == '0))
      else $error("data_out not zero during reset");

   // the fill takes DEPTH edges and the read pipeline two more.
   valid_low_during_fill : assert property (@(posedge clk) disable iff (rst)
      (since_release <= DEPTH + 2) |-> !playback_valid)
      else $error("playback_valid high before the fill and read latency were over");

endmodule

bind capture_playback_top capture_playback_sva capture_playback_sva_inst (
   .clk            (clk),
   .rst            (rst),
   .data_out       (data_out),
   .playback_valid (playback_valid)
);

// ==== tb_capture_playback.sv ====
`timescale 1ns/100ps

module tb_capture_playback;

   import capture_pkg::*;

   localparam int unsigned SEED          = 32'h41c00906;
   localparam int          HALF_PERIOD   = 4;
   localparam int          RESET_CYCLES  = 10;
   localparam int          VALID_TIMEOUT = 64;    // cycles allowed after the last word goes in.
   localparam int          RESTART_AFTER = 300;   // words played before the mid-run reset.

   logic              clk;
   logic              rst;
   logic [DATA_W-1:0] data_in;
   logic [DATA_W-1:0] data_out;
   logic              playback_valid;

   logic [DATA_W-1:0] model [DEPTH];   // expected words in capture order.
   int unsigned       edge_cnt;        // edges since rst was first sampled low.
   int                errors;
   bit                timed_out;

   capture_playback_top capture_playback_top_inst (
      .clk            (clk),
      .rst            (rst),
      .data_in        (data_in),
      .data_out       (data_out),
      .playback_valid (playback_valid)
   );

   always #HALF_PERIOD clk = ~clk;

   // after edge e of a capture this reads e + 1.
   always @(posedge clk) begin
      if (rst) begin
         edge_cnt <= 0;
      end else begin
         edge_cnt <= edge_cnt + 1;
      end
   end

   task automatic check_word(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         errors++;
         $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_idle();
      check_flag("playback_valid", playback_valid, 1'b0);
      check_word("data_out", data_out, '0);
   endtask

   // a fresh random pattern goes into the model first. rst is then held for
   // RESET_CYCLES edges, and the pattern is fed in so that word k is
   // sampled at edge k. the outputs must stay idle the whole time.
   task automatic reset_and_fill();
      for (int k = 0; k < DEPTH; k++) begin
         model[k] = $urandom();
      end
      @(posedge clk);
      rst <= 1'b1;
      for (int i = 0; i < RESET_CYCLES; i++) begin
         @(posedge clk);
         if (i == RESET_CYCLES - 1) begin
            rst     <= 1'b0;
            data_in <= model[0];   // taken at edge 0.
         end
         @(negedge clk);
         check_idle();
      end
      for (int k = 1; k < DEPTH; k++) begin
         @(posedge clk);
         data_in <= model[k];
         @(negedge clk);
         check_idle();
      end
   endtask

   // waits for the first playback word and checks the edge it came after.
   task automatic wait_for_valid();
      int waited = 0;
      while (!playback_valid && waited < VALID_TIMEOUT) begin
         check_word("data_out", data_out, '0);
         @(negedge clk);
         waited++;
      end
      if (!playback_valid) begin
         errors++;
         timed_out = 1'b1;
         $display("timeout: playback_valid did not rise within %0d cycles after the fill",
                  VALID_TIMEOUT);
      end else begin
         // word 0 belongs after edge DEPTH+2.
         assert (edge_cnt == DEPTH + 3) else begin
            errors++;
            $display("ERROR t=%0t playback_valid rise edge got %0d expected %0d",
                     $time, edge_cnt - 1, DEPTH + 2);
         end
      end
   endtask

   // the current negedge must show word 0. on return the next negedge is
   // reached, which shows word count.
   task automatic check_words(input int count, input bit scramble);
      for (int k = 0; k < count; k++) begin
         check_flag("playback_valid", playback_valid, 1'b1);
         check_word("data_out", data_out, model[k]);
         @(posedge clk);
         if (scramble) begin
            data_in <= $urandom();
         end
         @(negedge clk);
      end
   endtask

   task automatic test_quiet_fill();
      reset_and_fill();
      wait_for_valid();
   endtask

   task automatic test_in_order();
      check_words(DEPTH, 1'b0);
   endtask

   task automatic test_wraparound();
      check_words(DEPTH, 1'b0);   // second lap, same words.
   endtask

   // new input during playback must not reach the banks.
   task automatic test_capture_closed();
      check_words(DEPTH, 1'b1);
   endtask

   task automatic test_recapture();
      check_words(RESTART_AFTER, 1'b1);
      reset_and_fill();
      wait_for_valid();
      if (!timed_out) begin
         check_words(DEPTH, 1'b1);
      end
   endtask

   initial begin
      clk       = 1'b0;
      rst       = 1'b1;
      data_in   = '0;
      errors    = 0;
      timed_out = 1'b0;
      void'($urandom(SEED));
      test_quiet_fill();
      if (!timed_out) begin
         test_in_order();
         test_wraparound();
         test_capture_closed();
         test_recapture();
      end
      $display("checks done with %0d errors", errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
capture_pkg.sv
capture_bank.sv
capture_writer.sv
playback_reader.sv
capture_playback_top.sv
capture_playback_sva.sv
tb_capture_playback.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_capture_playback -f sources.f -o sim_capture_playback

out="$(./obj_dir/sim_capture_playback || true)"
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
   exit 0
fi
exit 1
